// ==== flist.f ====
verilog/pcie_ep_pkg.sv
verilog/pcie_ep_if.sv
verilog/pcie_rx_engine.sv
verilog/pcie_trg_bridge.sv
verilog/pcie_usr_regs.sv
verilog/pcie_tx_engine.sv
verilog/pcie_intr_ctrl.sv
verilog/pcie_ep_top.sv
testbench/tb_clkgen.sv
testbench/tb_pcie_ep.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the PCIe endpoint testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir run.log
verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_pcie_ep -o sim_tb
./obj_dir/sim_tb > run.log 2>&1 || true
cat run.log

if grep -q "Simulation completed successfully" run.log; then
  exit 0
else
  exit 1
fi

// ==== testbench/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
  output logic clk_o,
  output logic rst_n_o
);
  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;        // 10 ns period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (8) @(posedge clk_o);     // Reset held for 8 cycles
    #1 rst_n_o = 1'b1;
  end
endmodule

// ==== testbench/tb_pcie_ep.sv ====
`timescale 1ns/1ps

module tb_pcie_ep;
  logic        clk, rst_n;
  logic [63:0] trn_rd, trn_td;
  logic [7:0]  trn_rrem_n, trn_trem_n, cfg_bus, cfg_int_di;
  logic        trn_rsof_n, trn_reof_n, trn_rsrc_rdy_n, trn_rsrc_dsc_n, trn_rdst_rdy_n;
  logic [6:0]  trn_rbar_hit_n;
  logic        trn_tsof_n, trn_teof_n, trn_tsrc_rdy_n, trn_tsrc_dsc_n;
  logic        trn_tdst_rdy_n, trn_tdst_dsc_n, trn_reset_n, trn_lnk_up_n;
  logic [4:0]  cfg_dev;
  logic [2:0]  cfg_func;
  logic [15:0] cfg_command;
  logic        int_rdy_n, msi_en, int_n, int_assert_n, to_turnoff_n, turnoff_ok_n;
  logic [31:0] dev_status, gctrl, dev_ctrl;

  logic [31:0]  model_mem [0:2];      // GCTRL, DEV_CTRL, SCRATCH
  logic         model_irq;
  logic [127:0] exp_q [$];            // Expected {beat1, beat2}
  logic [63:0]  beat1;
  logic [1:0]   stall_mode;           // 0 none, 1 random, 2 held
  logic         msg_assert_n [$];     // assert_n of each taken interrupt
  int           err_cnt, tmo_cnt, cpl_cnt;
  logic [7:0]   tag_cnt;

  tb_clkgen clkgen_i (.clk_o(clk), .rst_n_o(rst_n));

  pcie_ep_top pcie_ep_top_i (
    .trn_clk_i(clk), .rst_n_i(rst_n), .trn_reset_n_i(trn_reset_n), .trn_lnk_up_n_i(trn_lnk_up_n),
    .trn_rd_i(trn_rd), .trn_rrem_n_i(trn_rrem_n), .trn_rsof_n_i(trn_rsof_n),
    .trn_reof_n_i(trn_reof_n), .trn_rsrc_rdy_n_i(trn_rsrc_rdy_n),
    .trn_rsrc_dsc_n_i(trn_rsrc_dsc_n), .trn_rbar_hit_n_i(trn_rbar_hit_n),
    .trn_rdst_rdy_n_o(trn_rdst_rdy_n), .trn_td_o(trn_td), .trn_trem_n_o(trn_trem_n),
    .trn_tsof_n_o(trn_tsof_n), .trn_teof_n_o(trn_teof_n), .trn_tsrc_rdy_n_o(trn_tsrc_rdy_n),
    .trn_tsrc_dsc_n_o(trn_tsrc_dsc_n), .trn_tdst_rdy_n_i(trn_tdst_rdy_n),
    .trn_tdst_dsc_n_i(trn_tdst_dsc_n), .cfg_bus_number_i(cfg_bus),
    .cfg_device_number_i(cfg_dev), .cfg_function_number_i(cfg_func),
    .cfg_command_i(cfg_command), .cfg_interrupt_rdy_n_i(int_rdy_n),
    .cfg_interrupt_msienable_i(msi_en), .cfg_interrupt_n_o(int_n),
    .cfg_interrupt_assert_n_o(int_assert_n), .cfg_interrupt_di_o(cfg_int_di),
    .cfg_to_turnoff_n_i(to_turnoff_n), .cfg_turnoff_ok_n_o(turnoff_ok_n),
    .p_in_dev_status_i(dev_status), .p_out_gctrl_o(gctrl), .p_out_dev_ctrl_o(dev_ctrl)
  );

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------
  function automatic logic [31:0] model_reg(input logic [2:0] idx);
    if (idx <= 3'd2) return model_mem[idx];
    if (idx == 3'd3) return {31'd0, model_irq};
    if (idx == 3'd4) return dev_status;
    return 32'd0;                                   // Unmapped
  endfunction

  task automatic model_write(input logic [2:0] idx, input logic [31:0] d, input logic [3:0] be);
    for (int b = 0; b < 4; b++) begin
      if (idx <= 3'd2 && be[b]) model_mem[idx][8*b +: 8] = d[8*b +: 8];
    end
    if (idx == 3'd3 && be[0]) begin
      if (d[0]) model_irq = 1'b1;
      else if (d[1]) model_irq = 1'b0;
    end
  endtask

  function automatic logic [127:0] exp_cpl(input logic [2:0] idx, input logic [31:0] d,
                                           input logic [15:0] rid, input logic [7:0] tag,
                                           input logic [2:0] tc, input logic [1:0] attr);
    logic [31:0] dw0, dw1, dw2;
    dw0 = {1'b0, 7'b1001010, 1'b0, tc, 4'd0, 2'b00, attr, 2'b00, 10'd1};  // CplD, length 1
    dw1 = {cfg_bus, cfg_dev, cfg_func, 3'b000, 1'b0, 12'd4};
    dw2 = {rid, tag, 1'b0, 2'b00, idx, 2'b00};      // Lower address = index * 4
    return {dw0, dw1, dw2, d};
  endfunction

  function automatic logic [63:0] mk_hdr(input logic [6:0] fmt, input logic [9:0] len,
                                         input logic [2:0] tc, input logic [1:0] attr,
                                         input logic [15:0] rid, input logic [7:0] tag,
                                         input logic [3:0] fbe);
    return {1'b0, fmt, 1'b0, tc, 4'd0, 2'b00, attr, 2'b00, len, rid, tag, 4'h0, fbe};
  endfunction

  // ------------------------------------------------------------------------
  // Receive link stimulus
  // ------------------------------------------------------------------------
  task automatic send_beat(input logic [63:0] d, input logic sof, input logic eof,
                           input logic [7:0] rrem);
    logic taken;
    int   n;
    trn_rd = d;
    trn_rsof_n = !sof;
    trn_reof_n = !eof;
    trn_rrem_n = rrem;
    trn_rsrc_rdy_n = 1'b0;
    taken = 1'b0;
    n = 0;
    while (!taken && n < 200) begin
      taken = !trn_rdst_rdy_n;                      // Stable mid-cycle
      @(posedge clk);
      #1;
      n++;
    end
    if (!taken) begin
      $display("Timeout at %0t: receive beat was never accepted", $time);
      tmo_cnt++;
    end
    trn_rsrc_rdy_n = 1'b1;
  endtask

  task automatic send_tlp(input logic [63:0] hdr, input logic [2:0] idx, input logic [31:0] d,
                          input logic [7:0] rrem, input logic bar_hit);
    trn_rbar_hit_n = bar_hit ? 7'h7e : 7'h7f;
    send_beat(hdr, 1'b1, 1'b0, 8'h00);
    send_beat({27'd0, idx, 2'b00, d}, 1'b0, 1'b1, rrem);
  endtask

  task automatic mem_wr(input logic [2:0] idx, input logic [31:0] d, input logic [3:0] be);
    send_tlp(mk_hdr(7'b1000000, 10'd1, 3'd0, 2'd0, 16'h0100, 8'h00, be), idx, d, 8'h00, 1'b1);
    model_write(idx, d, be);
  endtask

  task automatic mem_rd(input logic [2:0] idx);
    logic [15:0] rid;
    rid = 16'h0a00 + 16'(tag_cnt);
    exp_q.push_back(exp_cpl(idx, model_reg(idx), rid, tag_cnt, tag_cnt[2:0], tag_cnt[4:3]));
    send_tlp(mk_hdr(7'b0000000, 10'd1, tag_cnt[2:0], tag_cnt[4:3], rid, tag_cnt, 4'hf),
             idx, 32'd0, 8'h0f, 1'b1);
    tag_cnt++;
  endtask

  task automatic wait_cpls;
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 5000) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout at %0t: %0d completions never arrived", $time, exp_q.size());
      tmo_cnt++;
      exp_q.delete();
    end
  endtask

  task automatic wait_msgs(input int cnt);
    int n;
    n = 0;
    while (msg_assert_n.size() < cnt && n < 200) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (msg_assert_n.size() < cnt) begin
      $display("Timeout at %0t: interrupt message was not sent", $time);
      tmo_cnt++;
    end
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  // ------------------------------------------------------------------------
  // Core-side responders and the completion monitor
  // ------------------------------------------------------------------------
  always @(posedge clk) begin
    #1;
    case (stall_mode)
      2'd0:    trn_tdst_rdy_n <= 1'b0;
      2'd1:    trn_tdst_rdy_n <= ($urandom % 3) == 0;   // Stall about one cycle in three
      default: trn_tdst_rdy_n <= 1'b1;
    endcase
    int_rdy_n <= int_n;                              // Take a message one cycle later
  end

  always @(negedge clk) begin
    if (!int_n && !int_rdy_n) begin
      msg_assert_n.push_back(int_assert_n);
      check_val("cfg_interrupt_di_o", 64'(cfg_int_di), 64'h0);
    end
    if (!trn_tsrc_rdy_n && !trn_tdst_rdy_n) begin
      if (!trn_tsof_n) beat1 = trn_td;
      if (!trn_teof_n) begin
        cpl_cnt++;
        check_val("trn_trem_n_o", 64'(trn_trem_n), 64'h0);
        check_val("trn_tsrc_dsc_n_o", 64'(trn_tsrc_dsc_n), 64'd1);
        assert (exp_q.size() != 0) else begin
          $display("Unexpected completion at %0t with no read outstanding", $time);
          err_cnt++;
        end
        if (exp_q.size() != 0) begin
          check_val("trn_td_o beat 1", beat1, exp_q[0][127:64]);
          check_val("trn_td_o beat 2", trn_td, exp_q[0][63:0]);
          void'(exp_q.pop_front());
        end
      end
    end
  end

  // ------------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------------
  initial begin
    int          seed_init;
    int          n;
    int          cpl_seen;
    logic [2:0]  idx;
    seed_init = $urandom(32'hb1e2053a);
    trn_rd         = '0;
    trn_rrem_n     = 8'h00;
    trn_rsof_n     = 1'b1;
    trn_reof_n     = 1'b1;
    trn_rsrc_rdy_n = 1'b1;
    trn_rsrc_dsc_n = 1'b1;
    trn_rbar_hit_n = 7'h7f;
    trn_tdst_rdy_n = 1'b0;
    trn_tdst_dsc_n = 1'b1;
    trn_reset_n    = 1'b1;
    trn_lnk_up_n   = 1'b0;
    cfg_bus        = 8'h5c;
    cfg_dev        = 5'd3;
    cfg_func       = 3'd1;
    cfg_command    = 16'h0006;
    int_rdy_n      = 1'b1;
    msi_en         = 1'b0;
    to_turnoff_n   = 1'b1;
    dev_status     = 32'hc0de5a17;
    model_mem[0]   = '0;
    model_mem[1]   = '0;
    model_mem[2]   = '0;
    model_irq      = 1'b0;
    stall_mode     = 2'd0;
    err_cnt        = 0;
    tmo_cnt        = 0;
    cpl_cnt        = 0;
    tag_cnt        = 8'h10;
    @(posedge rst_n);
    repeat (3) @(posedge clk);
    #1;

    // Idle link and sideband after reset
    check_val("trn_tsrc_rdy_n_o", 64'(trn_tsrc_rdy_n), 64'd1);
    check_val("trn_rdst_rdy_n_o", 64'(trn_rdst_rdy_n), 64'd0);
    check_val("cfg_interrupt_n_o", 64'(int_n), 64'd1);
    check_val("cfg_turnoff_ok_n_o", 64'(turnoff_ok_n), 64'd1);

    // Full-dword write and read-back
    mem_wr(3'd0, 32'h1234abcd, 4'hf);
    mem_wr(3'd1, 32'h0badf00d, 4'hf);
    mem_wr(3'd2, 32'hdeadbeef, 4'hf);
    for (int i = 0; i < 3; i++) mem_rd(3'(i));
    wait_cpls();
    check_val("p_out_gctrl_o", 64'(gctrl), 64'(model_mem[0]));
    check_val("p_out_dev_ctrl_o", 64'(dev_ctrl), 64'(model_mem[1]));

    // Byte-enable merging
    mem_wr(3'd2, 32'h11223344, 4'b0001);
    mem_wr(3'd0, 32'h55667788, 4'b0110);
    mem_wr(3'd1, 32'h99aabbcc, 4'b1000);
    mem_wr(3'd2, 32'h0f0f0f0f, 4'b1010);
    for (int i = 0; i < 3; i++) mem_rd(3'(i));
    wait_cpls();

    // Status, unmapped and dropped packets
    mem_rd(3'd4);
    mem_rd(3'd6);
    send_tlp(mk_hdr(7'b0000000, 10'd2, 3'd0, 2'd0, 16'h0100, 8'h01, 4'hf), 3'd0, 0, 8'h0f, 1);
    send_tlp(mk_hdr(7'b1000000, 10'd1, 3'd0, 2'd0, 16'h0100, 8'h02, 4'hf), 3'd0, 1, 8'h00, 0);
    send_tlp(mk_hdr(7'b1100000, 10'd1, 3'd0, 2'd0, 16'h0100, 8'h03, 4'hf), 3'd1, 2, 8'h00, 1);
    for (int i = 0; i < 3; i++) mem_rd(3'(i));
    wait_cpls();

    // Back-pressure on the transmit link
    stall_mode = 2'd1;
    for (int i = 0; i < 40; i++) begin
      idx = 3'($urandom % 5);
      mem_rd(idx);
    end
    wait_cpls();
    stall_mode = 2'd0;

    // Legacy INTx assert then deassert
    mem_wr(3'd3, 32'h1, 4'h1);
    wait_msgs(1);
    mem_wr(3'd3, 32'h2, 4'h1);
    wait_msgs(2);
    repeat (20) @(posedge clk);
    #1;
    check_val("interrupt message count", 64'(msg_assert_n.size()), 64'd2);
    if (msg_assert_n.size() == 2) begin
      check_val("cfg_interrupt_assert_n_o", 64'(msg_assert_n[0]), 64'd0);
      check_val("cfg_interrupt_assert_n_o", 64'(msg_assert_n[1]), 64'd1);
    end
    msg_assert_n.delete();

    // Interrupt Disable masks INTx
    cfg_command = 16'h0406;
    mem_wr(3'd3, 32'h1, 4'h1);
    repeat (30) @(posedge clk);
    #1;
    mem_wr(3'd3, 32'h2, 4'h1);
    repeat (30) @(posedge clk);
    #1;
    check_val("interrupt message count", 64'(msg_assert_n.size()), 64'd0);
    cfg_command = 16'h0006;

    // MSI on a rise of the pending bit
    msi_en = 1'b1;
    mem_wr(3'd3, 32'h1, 4'h1);
    wait_msgs(1);
    mem_wr(3'd3, 32'h2, 4'h1);
    repeat (30) @(posedge clk);
    #1;
    check_val("interrupt message count", 64'(msg_assert_n.size()), 64'd1);
    if (msg_assert_n.size() != 0) begin
      check_val("cfg_interrupt_assert_n_o", 64'(msg_assert_n[0]), 64'd1);
    end
    msg_assert_n.delete();
    msi_en = 1'b0;

    // Turn-off with a read in flight, completion held by the core
    stall_mode = 2'd2;
    cpl_seen = cpl_cnt;
    mem_rd(3'd2);
    to_turnoff_n = 1'b0;
    repeat (10) @(posedge clk);
    stall_mode = 2'd0;
    n = 0;
    while (cpl_cnt == cpl_seen && n < 200) begin
      @(negedge clk);
      n++;
      assert (turnoff_ok_n) else begin
        $display("Turn-off granted at %0t while a completion was pending", $time);
        err_cnt++;
      end
    end
    if (cpl_cnt == cpl_seen) begin
      $display("Timeout at %0t: held completion was never sent", $time);
      tmo_cnt++;
    end
    n = 0;
    while (turnoff_ok_n && n < 100) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (turnoff_ok_n) begin
      $display("Timeout at %0t: turn-off was never granted", $time);
      tmo_cnt++;
    end
    #1 to_turnoff_n = 1'b1;
    repeat (3) @(posedge clk);
    check_val("cfg_turnoff_ok_n_o", 64'(turnoff_ok_n), 64'd1);
    wait_cpls();

    $display("Checks done: %0d errors, %0d timeouts", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verilog/pcie_ep_if.sv ====
`timescale 1ns/1ps

// Request from the receive engine to the bridge
interface trg_req_if;
  import pcie_ep_pkg::*;

  logic                 valid;
  logic                 ready;
  logic                 is_rd;    // 1 - MRd, 0 - MWr
  logic [REG_IDX_W-1:0] idx;      // Dword index in BAR0
  logic [DW_W-1:0]      data;
  logic [3:0]           fbe;
  logic [15:0]          rid;
  logic [7:0]           tag;
  logic [2:0]           tc;
  logic [1:0]           attr;

  modport rx  (output valid, is_rd, idx, data, fbe, rid, tag, tc, attr, input ready);
  modport brg (input valid, is_rd, idx, data, fbe, rid, tag, tc, attr, output ready);
endinterface

// Wishbone classic, bridge to register file
interface wb_if;
  import pcie_ep_pkg::*;

  logic                 cyc;
  logic                 stb;
  logic                 we;
  logic [REG_IDX_W-1:0] adr;
  logic [3:0]           sel;
  logic [DW_W-1:0]      dat_w;
  logic [DW_W-1:0]      dat_r;
  logic                 ack;

  modport mst (output cyc, stb, we, adr, sel, dat_w, input dat_r, ack);
  modport slv (input cyc, stb, we, adr, sel, dat_w, output dat_r, ack);
endinterface

// Completion job, bridge to transmit engine
interface cpl_if;
  import pcie_ep_pkg::*;

  logic            valid;
  logic            done;     // Pulse on the last beat taken
  logic [DW_W-1:0] data;
  logic [15:0]     rid;
  logic [7:0]      tag;
  logic [2:0]      tc;
  logic [1:0]      attr;
  logic [6:0]      laddr;    // Lower address

  modport brg (output valid, data, rid, tag, tc, attr, laddr, input done);
  modport tx  (input valid, data, rid, tag, tc, attr, laddr, output done);
endinterface

// ==== verilog/pcie_ep_pkg.sv ====
package pcie_ep_pkg;

  // -------------------------------------------------------------------------
  // Local-link and TLP encodings
  // -------------------------------------------------------------------------
  localparam int TRN_DW = 64;                    // 64-bit local-link
  localparam int DW_W   = 32;

  localparam logic [6:0] FMT_MWR32 = 7'b10_00000; // 3DW header, with data
  localparam logic [6:0] FMT_MRD32 = 7'b00_00000; // 3DW header, no data
  localparam logic [6:0] FMT_CPLD  = 7'b10_01010; // Completion with data

  // -------------------------------------------------------------------------
  // BAR0 register map, dword indices
  // -------------------------------------------------------------------------
  localparam int REG_IDX_W = 3;

  localparam logic [REG_IDX_W-1:0] REG_GCTRL      = 3'd0;
  localparam logic [REG_IDX_W-1:0] REG_DEV_CTRL   = 3'd1;
  localparam logic [REG_IDX_W-1:0] REG_SCRATCH    = 3'd2;
  localparam logic [REG_IDX_W-1:0] REG_IRQ        = 3'd3; // Pending bit, set/clear
  localparam logic [REG_IDX_W-1:0] REG_DEV_STATUS = 3'd4; // Read only

  localparam int IRQ_SET_BIT     = 0;
  localparam int IRQ_CLR_BIT     = 1;
  localparam int CFG_BAR0_BIT    = 0;    // Into trn_rbar_hit_n
  localparam int CFG_INT_DIS_BIT = 10;   // Command reg, Interrupt Disable

  // FSM state codes
  localparam logic [1:0] RX_HDR  = 2'd0;
  localparam logic [1:0] RX_DATA = 2'd1;
  localparam logic [1:0] RX_HOLD = 2'd2;
  localparam logic [1:0] BR_IDLE = 2'd0;
  localparam logic [1:0] BR_WB   = 2'd1;
  localparam logic [1:0] BR_CPL  = 2'd2;
  localparam logic [1:0] TX_IDLE = 2'd0;
  localparam logic [1:0] TX_B1   = 2'd1;
  localparam logic [1:0] TX_B2   = 2'd2;

  // Header DW1, request view on receive and completion view on transmit
  typedef union packed {
    struct packed {
      logic [15:0] rid;
      logic [7:0]  tag;
      logic [3:0]  lbe;
      logic [3:0]  fbe;
    } req;
    struct packed {
      logic [15:0] cid;
      logic [2:0]  status;
      logic        bcm;
      logic [11:0] byte_cnt;
    } cpl;
  } tlp_dw1_u;

endpackage

// ==== verilog/pcie_ep_top.sv ====
`timescale 1ns/1ps

module pcie_ep_top (
  input  logic                           trn_clk_i,
  input  logic                           rst_n_i,
  input  logic                           trn_reset_n_i,
  input  logic                           trn_lnk_up_n_i,
  // Rx local-link
  input  logic [pcie_ep_pkg::TRN_DW-1:0] trn_rd_i,
  input  logic [7:0]                     trn_rrem_n_i,
  input  logic                           trn_rsof_n_i,
  input  logic                           trn_reof_n_i,
  input  logic                           trn_rsrc_rdy_n_i,
  input  logic                           trn_rsrc_dsc_n_i,
  input  logic [6:0]                     trn_rbar_hit_n_i,
  output logic                           trn_rdst_rdy_n_o,
  // Tx local-link
  output logic [pcie_ep_pkg::TRN_DW-1:0] trn_td_o,
  output logic [7:0]                     trn_trem_n_o,
  output logic                           trn_tsof_n_o,
  output logic                           trn_teof_n_o,
  output logic                           trn_tsrc_rdy_n_o,
  output logic                           trn_tsrc_dsc_n_o,
  input  logic                           trn_tdst_rdy_n_i,
  input  logic                           trn_tdst_dsc_n_i,
  // Configuration
  input  logic [7:0]                     cfg_bus_number_i,
  input  logic [4:0]                     cfg_device_number_i,
  input  logic [2:0]                     cfg_function_number_i,
  input  logic [15:0]                    cfg_command_i,
  input  logic                           cfg_interrupt_rdy_n_i,
  input  logic                           cfg_interrupt_msienable_i,
  output logic                           cfg_interrupt_n_o,
  output logic                           cfg_interrupt_assert_n_o,
  output logic [7:0]                     cfg_interrupt_di_o,
  input  logic                           cfg_to_turnoff_n_i,
  output logic                           cfg_turnoff_ok_n_o,
  // User side
  input  logic [pcie_ep_pkg::DW_W-1:0]   p_in_dev_status_i,
  output logic [pcie_ep_pkg::DW_W-1:0]   p_out_gctrl_o,
  output logic [pcie_ep_pkg::DW_W-1:0]   p_out_dev_ctrl_o
);

  logic        rst_n;          // Held in reset while the link is down
  logic [15:0] completer_id;
  logic        irq_pend;

  trg_req_if req_if ();
  wb_if      wb_bus ();
  cpl_if     cpl_bus ();

  assign rst_n              = rst_n_i && trn_reset_n_i && !trn_lnk_up_n_i;
  assign completer_id       = {cfg_bus_number_i, cfg_device_number_i, cfg_function_number_i};
  assign cfg_interrupt_di_o = 8'h00;   // Single vector
  assign trn_tsrc_dsc_n_o   = 1'b1;    // Never discontinue

  pcie_rx_engine m_rx (
    .trn_clk_i, .rst_n_i(rst_n), .trn_rd_i, .trn_rrem_n_i, .trn_rsof_n_i, .trn_reof_n_i,
    .trn_rsrc_rdy_n_i, .trn_rsrc_dsc_n_i, .trn_rbar_hit_n_i, .trn_rdst_rdy_n_o,
    .req(req_if.rx)
  );

  pcie_trg_bridge m_bridge (
    .trn_clk_i, .rst_n_i(rst_n), .req(req_if.brg), .wb(wb_bus.mst), .cpl(cpl_bus.brg),
    .cfg_to_turnoff_n_i, .cfg_turnoff_ok_n_o
  );

  pcie_usr_regs m_regs (
    .trn_clk_i, .rst_n_i(rst_n), .wb(wb_bus.slv), .p_in_dev_status_i,
    .p_out_gctrl_o, .p_out_dev_ctrl_o, .irq_pend_o(irq_pend)
  );

  pcie_tx_engine m_tx (
    .trn_clk_i, .rst_n_i(rst_n), .trn_td_o, .trn_trem_n_o, .trn_tsof_n_o, .trn_teof_n_o,
    .trn_tsrc_rdy_n_o, .trn_tdst_rdy_n_i, .trn_tdst_dsc_n_i,
    .completer_id_i(completer_id), .cpl(cpl_bus.tx)
  );

  pcie_intr_ctrl m_intr (
    .trn_clk_i, .rst_n_i(rst_n), .irq_pend_i(irq_pend), .cfg_command_i,
    .cfg_interrupt_msienable_i, .cfg_interrupt_rdy_n_i, .cfg_interrupt_n_o,
    .cfg_interrupt_assert_n_o
  );

endmodule

// ==== verilog/pcie_intr_ctrl.sv ====
`timescale 1ns/1ps

module pcie_intr_ctrl (
  input  logic        trn_clk_i,
  input  logic        rst_n_i,
  input  logic        irq_pend_i,
  input  logic [15:0] cfg_command_i,
  input  logic        cfg_interrupt_msienable_i,
  input  logic        cfg_interrupt_rdy_n_i,
  output logic        cfg_interrupt_n_o,
  output logic        cfg_interrupt_assert_n_o
);
  import pcie_ep_pkg::*;

  logic pend_d_q;    // Previous pending bit
  logic msi_req_q;   // MSI waiting to go
  logic line_q;      // INTx level last sent
  logic legacy_go;
  logic msi_go;

  // INTx follows the pending level, masked by Interrupt Disable
  assign legacy_go = !cfg_interrupt_msienable_i && !cfg_command_i[CFG_INT_DIS_BIT]
                     && (irq_pend_i != line_q);
  assign msi_go    = cfg_interrupt_msienable_i && msi_req_q;

  always_ff @(posedge trn_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pend_d_q                 <= 1'b0;
      msi_req_q                <= 1'b0;
      line_q                   <= 1'b0;
      cfg_interrupt_n_o        <= 1'b1;
      cfg_interrupt_assert_n_o <= 1'b1;
    end else begin
      pend_d_q <= irq_pend_i;
      if (!cfg_interrupt_n_o) begin
        if (!cfg_interrupt_rdy_n_i) cfg_interrupt_n_o <= 1'b1; // Core took it
      end else if (msi_go) begin
        cfg_interrupt_n_o        <= 1'b0;
        cfg_interrupt_assert_n_o <= 1'b1;  // MSI ignores assert_n
        msi_req_q                <= 1'b0;
      end else if (legacy_go) begin
        cfg_interrupt_n_o        <= 1'b0;
        cfg_interrupt_assert_n_o <= !irq_pend_i;  // Assert or deassert INTA
        line_q                   <= irq_pend_i;
      end
      // New rise wins over a clear in the same cycle
      if (cfg_interrupt_msienable_i && irq_pend_i && !pend_d_q) msi_req_q <= 1'b1;
    end
  end

endmodule

// ==== verilog/pcie_rx_engine.sv ====
`timescale 1ns/1ps

module pcie_rx_engine (
  input  logic                           trn_clk_i,
  input  logic                           rst_n_i,
  input  logic [pcie_ep_pkg::TRN_DW-1:0] trn_rd_i,
  input  logic [7:0]                     trn_rrem_n_i,
  input  logic                           trn_rsof_n_i,
  input  logic                           trn_reof_n_i,
  input  logic                           trn_rsrc_rdy_n_i,
  input  logic                           trn_rsrc_dsc_n_i,
  input  logic [6:0]                     trn_rbar_hit_n_i,
  output logic                           trn_rdst_rdy_n_o,
  trg_req_if.rx                          req
);
  import pcie_ep_pkg::*;

  logic [1:0] state_q;
  logic [1:0] state_d;
  logic       beat;       // Beat taken this cycle
  logic       hit_q;      // Header passed every check
  logic       wr_ok;
  logic       hdr_ok;
  logic [6:0] fmt_type;
  tlp_dw1_u   dw1;

  assign beat     = !trn_rsrc_rdy_n_i && !trn_rdst_rdy_n_o;
  assign fmt_type = trn_rd_i[62:56];
  assign dw1      = trn_rd_i[DW_W-1:0];

  // MWr32/MRd32, one dword, hit on BAR0
  assign hdr_ok = (fmt_type == FMT_MWR32 || fmt_type == FMT_MRD32)
                  && trn_rd_i[41:32] == 10'd1
                  && dw1.req.lbe == 4'h0
                  && !trn_rbar_hit_n_i[CFG_BAR0_BIT];

  assign wr_ok     = req.is_rd || trn_rrem_n_i == 8'h00; // Write needs data dword valid
  assign req.valid = (state_q == RX_HOLD);

  always_comb begin
    state_d = state_q;
    case (state_q)
      RX_HDR:  if (beat && !trn_rsof_n_i && trn_reof_n_i && trn_rsrc_dsc_n_i) state_d = RX_DATA;
      RX_DATA: begin
        if (!trn_rsrc_dsc_n_i) begin
          state_d = RX_HDR;                           // Discontinued, drop
        end else if (beat && !trn_reof_n_i) begin
          state_d = (hit_q && wr_ok) ? RX_HOLD : RX_HDR;
        end
      end
      RX_HOLD: if (req.ready) state_d = RX_HDR;       // Bridge took it
      default: state_d = RX_HDR;
    endcase
  end

  always_ff @(posedge trn_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q          <= RX_HDR;
      hit_q            <= 1'b0;
      trn_rdst_rdy_n_o <= 1'b1;
    end else begin
      state_q          <= state_d;
      trn_rdst_rdy_n_o <= (state_d == RX_HOLD); // Stall while a request waits
      if (state_q == RX_HDR && beat && !trn_rsof_n_i) begin
        hit_q <= hdr_ok;
      end else if (state_q == RX_DATA && beat) begin
        hit_q <= 1'b0;    // Longer packets fall through
      end
    end
  end

  // Request fields, held while valid
  always_ff @(posedge trn_clk_i) begin
    if (state_q == RX_HDR && beat && !trn_rsof_n_i) begin
      req.is_rd <= (fmt_type == FMT_MRD32);
      req.tc    <= trn_rd_i[54:52];
      req.attr  <= trn_rd_i[45:44];
      req.rid   <= dw1.req.rid;
      req.tag   <= dw1.req.tag;
      req.fbe   <= dw1.req.fbe;
    end
    if (state_q == RX_DATA && beat) begin
      req.idx  <= trn_rd_i[DW_W+2 +: REG_IDX_W]; // DW2 address bits above 1:0
      req.data <= trn_rd_i[DW_W-1:0];
    end
  end

endmodule

// ==== verilog/pcie_trg_bridge.sv ====
`timescale 1ns/1ps

module pcie_trg_bridge (
  input  logic   trn_clk_i,
  input  logic   rst_n_i,
  trg_req_if.brg req,
  wb_if.mst      wb,
  cpl_if.brg     cpl,
  input  logic   cfg_to_turnoff_n_i,
  output logic   cfg_turnoff_ok_n_o
);
  import pcie_ep_pkg::*;

  logic [1:0] state_q;
  logic       take;     // Request accepted

  assign take      = req.valid && req.ready;
  assign req.ready = (state_q == BR_IDLE);
  assign wb.cyc    = (state_q == BR_WB);
  assign wb.stb    = (state_q == BR_WB);
  assign cpl.valid = (state_q == BR_CPL);

  // -------------------------------------------------------------------------
  // Control FSM and turn-off answer
  // -------------------------------------------------------------------------
  always_ff @(posedge trn_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q            <= BR_IDLE;
      cfg_turnoff_ok_n_o <= 1'b1;
    end else begin
      case (state_q)
        BR_IDLE: if (take) state_q <= BR_WB;
        BR_WB:   if (wb.ack) state_q <= wb.we ? BR_IDLE : BR_CPL; // Writes end here
        BR_CPL:  if (cpl.done) state_q <= BR_IDLE;
        default: state_q <= BR_IDLE;
      endcase

      if (cfg_to_turnoff_n_i) begin
        cfg_turnoff_ok_n_o <= 1'b1;
      end else if (state_q == BR_IDLE && !req.valid) begin
        cfg_turnoff_ok_n_o <= 1'b0;            // Nothing outstanding
      end
    end
  end

  // Latched request and read data
  always_ff @(posedge trn_clk_i) begin
    if (take) begin
      wb.we     <= !req.is_rd;
      wb.adr    <= req.idx;
      wb.sel    <= req.fbe;
      wb.dat_w  <= req.data;
      cpl.rid   <= req.rid;
      cpl.tag   <= req.tag;
      cpl.tc    <= req.tc;
      cpl.attr  <= req.attr;
      cpl.laddr <= 7'({req.idx, 2'b00});   // Dword index * 4
    end
    if (state_q == BR_WB && wb.ack) begin
      cpl.data <= wb.dat_r;
    end
  end

endmodule

// ==== verilog/pcie_tx_engine.sv ====
`timescale 1ns/1ps

module pcie_tx_engine (
  input  logic                           trn_clk_i,
  input  logic                           rst_n_i,
  output logic [pcie_ep_pkg::TRN_DW-1:0] trn_td_o,
  output logic [7:0]                     trn_trem_n_o,
  output logic                           trn_tsof_n_o,
  output logic                           trn_teof_n_o,
  output logic                           trn_tsrc_rdy_n_o,
  input  logic                           trn_tdst_rdy_n_i,
  input  logic                           trn_tdst_dsc_n_i,
  input  logic [15:0]                    completer_id_i,
  cpl_if.tx                              cpl
);
  import pcie_ep_pkg::*;

  logic [1:0]      state_q;
  logic            abort_q;   // Packet cut by the core
  logic            step;      // Current beat leaves the bus
  logic [DW_W-1:0] dw0;
  tlp_dw1_u        dw1;
  logic [DW_W-1:0] dw2;

  // -------------------------------------------------------------------------
  // CplD header, 3DW, length 1
  // -------------------------------------------------------------------------
  // R, fmt/type, R, TC, R, TD, EP, attr, R, length
  assign dw0 = {1'b0, FMT_CPLD, 1'b0, cpl.tc, 4'b0000, 1'b0, 1'b0, cpl.attr, 2'b00, 10'd1};

  always_comb begin
    dw1              = '0;
    dw1.cpl.cid      = completer_id_i;
    dw1.cpl.status   = 3'b000;     // Successful Completion
    dw1.cpl.bcm      = 1'b0;
    dw1.cpl.byte_cnt = 12'd4;      // Whole dword
  end

  assign dw2 = {cpl.rid, cpl.tag, 1'b0, cpl.laddr};

  // Beats held from the job fields, stable until done
  assign step             = !trn_tdst_rdy_n_i || !trn_tdst_dsc_n_i;
  assign trn_td_o         = (state_q == TX_B2) ? {dw2, cpl.data} : {dw0, dw1};
  assign trn_trem_n_o     = 8'h00;   // Both dwords valid in either beat
  assign trn_tsrc_rdy_n_o = (state_q == TX_IDLE);
  assign trn_tsof_n_o     = (state_q != TX_B1);
  assign trn_teof_n_o     = (state_q != TX_B2);

  assign cpl.done = (state_q == TX_B2) && !trn_tdst_rdy_n_i && trn_tdst_dsc_n_i && !abort_q;

  always_ff @(posedge trn_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= TX_IDLE;
      abort_q <= 1'b0;
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (cpl.valid) begin
            state_q <= TX_B1;
            abort_q <= 1'b0;
          end
        end
        TX_B1: begin
          if (step) begin
            state_q <= TX_B2;
            abort_q <= !trn_tdst_dsc_n_i;   // Close with teof, resend after
          end
        end
        TX_B2:   if (step) state_q <= TX_IDLE; // Job stays valid on abort
        default: state_q <= TX_IDLE;
      endcase
    end
  end

endmodule

// ==== verilog/pcie_usr_regs.sv ====
`timescale 1ns/1ps

module pcie_usr_regs (
  input  logic                         trn_clk_i,
  input  logic                         rst_n_i,
  wb_if.slv                            wb,
  input  logic [pcie_ep_pkg::DW_W-1:0] p_in_dev_status_i,
  output logic [pcie_ep_pkg::DW_W-1:0] p_out_gctrl_o,
  output logic [pcie_ep_pkg::DW_W-1:0] p_out_dev_ctrl_o,
  output logic                         irq_pend_o
);
  import pcie_ep_pkg::*;

  logic [DW_W-1:0] scratch_q;
  logic [DW_W-1:0] bmask;      // sel expanded to bits
  logic            acc;        // New access, ack goes out next cycle
  logic            wr;

  assign acc   = wb.cyc && wb.stb && !wb.ack;
  assign wr    = acc && wb.we;
  assign bmask = {{8{wb.sel[3]}}, {8{wb.sel[2]}}, {8{wb.sel[1]}}, {8{wb.sel[0]}}};

  function automatic logic [DW_W-1:0] merge(input logic [DW_W-1:0] old_v,
                                            input logic [DW_W-1:0] new_v,
                                            input logic [DW_W-1:0] mask);
    merge = (old_v & ~mask) | (new_v & mask);
  endfunction

  always_ff @(posedge trn_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb.ack           <= 1'b0;
      p_out_gctrl_o    <= '0;
      p_out_dev_ctrl_o <= '0;
      irq_pend_o       <= 1'b0;
    end else begin
      wb.ack <= acc;                  // One cycle, registered
      if (wr && wb.adr == REG_GCTRL) p_out_gctrl_o <= merge(p_out_gctrl_o, wb.dat_w, bmask);
      if (wr && wb.adr == REG_DEV_CTRL) begin
        p_out_dev_ctrl_o <= merge(p_out_dev_ctrl_o, wb.dat_w, bmask);
      end
      if (wr && wb.adr == REG_IRQ && wb.sel[0]) begin
        if (wb.dat_w[IRQ_SET_BIT]) irq_pend_o <= 1'b1;
        else if (wb.dat_w[IRQ_CLR_BIT]) irq_pend_o <= 1'b0;
      end
    end
  end

  // Scratch and read mux
  always_ff @(posedge trn_clk_i) begin
    if (wr && wb.adr == REG_SCRATCH) scratch_q <= merge(scratch_q, wb.dat_w, bmask);
    if (acc) begin
      case (wb.adr)
        REG_GCTRL:      wb.dat_r <= p_out_gctrl_o;
        REG_DEV_CTRL:   wb.dat_r <= p_out_dev_ctrl_o;
        REG_SCRATCH:    wb.dat_r <= scratch_q;
        REG_IRQ:        wb.dat_r <= {{(DW_W-1){1'b0}}, irq_pend_o};
        REG_DEV_STATUS: wb.dat_r <= p_in_dev_status_i;
        default:        wb.dat_r <= '0;       // Unmapped
      endcase
    end
  end

endmodule
